// File: project.f
+incdir+verif
hdl/icache_pkg.sv
hdl/fetch_port.sv
hdl/refill_port.sv
hdl/icache_core.sv
hdl/icache_top.sv
verif/icache_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
SIM_BIN=icache_sim

verilator --binary --timing --assert \
    --top-module icache_tb \
    --Mdir "${BUILD_DIR}" \
    -o "${SIM_BIN}" \
    -f project.f

"./${BUILD_DIR}/${SIM_BIN}"

// File: verif/icache_model.svh
`ifndef ICACHE_MODEL_SVH
`define ICACHE_MODEL_SVH

// ####################
// Reference model
// ####################

localparam int TAG_BITS   = ADDR_BITS - INDEX_BITS;
localparam int LINE_COUNT = 1 << INDEX_BITS;

// Backing memory, plus a shadow of the tag and valid bit held by each line.
word_t               mem_image [0:(1 << ADDR_BITS)-1];
logic [TAG_BITS-1:0] shadow_tag [LINE_COUNT];
logic                shadow_valid [LINE_COUNT];

function automatic void fill_image();
    for (int i = 0; i < (1 << ADDR_BITS); i++)
        mem_image[i] = $urandom;
endfunction

function automatic void clear_lines();
    for (int i = 0; i < LINE_COUNT; i++)
        shadow_valid[i] = 1'b0;
endfunction

// Direct mapped, so only the line at the index can hold the word.
function automatic logic predict_hit(input addr_t addr);
    logic [INDEX_BITS-1:0] line_index;
    line_index = addr[INDEX_BITS-1:0];
    return shadow_valid[line_index] && (shadow_tag[line_index] == addr[ADDR_BITS-1:INDEX_BITS]);
endfunction

function automatic void fill_line(input addr_t addr);
    logic [INDEX_BITS-1:0] line_index;
    line_index = addr[INDEX_BITS-1:0];
    shadow_valid[line_index] = 1'b1;
    shadow_tag[line_index]   = addr[ADDR_BITS-1:INDEX_BITS];
endfunction

`endif

// File: verif/icache_tb.sv
`timescale 1ns/100ps

module icache_tb
    import icache_pkg::*;
();

    localparam int INDEX_BITS     = 4;
    localparam int NUM_FETCHES    = 400;
    localparam int WINDOW_BASE    = 16'h3a40;
    localparam int WINDOW_WORDS   = 64;
    localparam int TIMEOUT_CYCLES = 200;

    localparam logic [1:0] R_IDLE  = 2'd0;
    localparam logic [1:0] R_DELAY = 2'd1;
    localparam logic [1:0] R_ACK   = 2'd2;

    logic       clk;
    logic       rst;
    logic       flush;
    logic       fetch_req;
    fetch_req_t fetch_req_data;
    logic       mem_ack;
    word_t      mem_data;
    logic       fetch_ack;
    fetch_rsp_t fetch_rsp;
    logic       mem_req;
    addr_t      mem_addr;

    addr_t expect_addr;
    int    mem_count;
    int    misses;

    `include "icache_model.svh"

    icache_top #(
        .INDEX_BITS (INDEX_BITS)
    ) u_dut (
        .clk            (clk),
        .rst            (rst),
        .flush          (flush),
        .fetch_req      (fetch_req),
        .fetch_req_data (fetch_req_data),
        .mem_ack        (mem_ack),
        .mem_data       (mem_data),
        .fetch_ack      (fetch_ack),
        .fetch_rsp      (fetch_rsp),
        .mem_req        (mem_req),
        .mem_addr       (mem_addr)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ####################
    // Checks
    // ####################

    task automatic end_with_failure();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_rsp(input fetch_rsp_t actual, input fetch_rsp_t expected);
        if (actual !== expected)
        begin
            $display("error at %0t: fetch_rsp data %h hit %b, expected data %h hit %b",
                     $time, actual.data, actual.hit, expected.data, expected.hit);
            end_with_failure();
        end
    endtask

    task automatic check_addr(input addr_t actual, input addr_t expected);
        if (actual !== expected)
        begin
            $display("error at %0t: mem_addr %h, expected %h", $time, actual, expected);
            end_with_failure();
        end
    endtask

    task automatic check_count(input int actual, input int expected);
        if (actual != expected)
        begin
            $display("error at %0t: %0d memory requests, expected %0d",
                     $time, actual, expected);
            end_with_failure();
        end
    endtask

    task automatic wait_for_ack(input logic level);
        int cycles;
        cycles = 0;
        do
        begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES)
            begin
                $display("The fetch handshake stalled with fetch_ack never reaching %b.", level);
                end_with_failure();
            end
        end
        while (fetch_ack !== level);
    endtask

    // ####################
    // Stimulus
    // ####################

    task automatic pulse_flush();
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
    endtask

    task automatic run_fetch(input addr_t addr, input int hold, input logic mid_flush);
        fetch_req_t req_word;
        fetch_rsp_t expected;
        int         count_before;
        req_word.addr = addr;
        expected.data = mem_image[addr];
        expected.hit  = predict_hit(addr);
        count_before  = mem_count;
        expect_addr   = addr;
        @(posedge clk);
        fetch_req      <= 1'b1;
        fetch_req_data <= req_word;
        // The cache holds this flush until the fetch is over.
        if (mid_flush)
            pulse_flush();
        wait_for_ack(1'b1);
        check_rsp(fetch_rsp, expected);
        repeat (hold)
        begin
            @(negedge clk);
            if (fetch_ack !== 1'b1)
            begin
                $display("fetch_ack dropped while fetch_req was still high.");
                end_with_failure();
            end
            check_rsp(fetch_rsp, expected);
        end
        @(posedge clk);
        fetch_req <= 1'b0;
        wait_for_ack(1'b0);
        check_count(mem_count - count_before, expected.hit ? 0 : 1);
        if (!expected.hit)
        begin
            fill_line(addr);
            misses++;
        end
        if (mid_flush)
            clear_lines();
    endtask

    // Memory answers each request after a few random cycles.
    initial
    begin : responder
        logic [1:0] state;
        int         delay;
        int         wait_cycles;
        logic       ack_next;
        word_t      data_next;
        mem_ack     = 1'b0;
        mem_data    = '0;
        mem_count   = 0;
        state       = R_IDLE;
        delay       = 0;
        wait_cycles = 0;
        ack_next    = 1'b0;
        data_next   = '0;
        forever
        begin
            @(negedge clk);
            case (state)
                R_IDLE:
                begin
                    if (mem_req === 1'b1)
                    begin
                        check_addr(mem_addr, expect_addr);
                        mem_count++;
                        delay = $urandom % 7;
                        state = R_DELAY;
                    end
                end
                R_DELAY:
                begin
                    if (delay == 0)
                    begin
                        ack_next    = 1'b1;
                        data_next   = mem_image[mem_addr];
                        wait_cycles = 0;
                        state       = R_ACK;
                    end
                    else
                        delay--;
                end
                default:
                begin
                    if (mem_req !== 1'b1)
                    begin
                        ack_next = 1'b0;
                        state    = R_IDLE;
                    end
                    else
                    begin
                        wait_cycles++;
                        if (wait_cycles > TIMEOUT_CYCLES)
                        begin
                            $display("The memory handshake stalled with mem_req held high.");
                            end_with_failure();
                        end
                    end
                end
            endcase
            @(posedge clk);
            mem_ack  <= ack_next;
            mem_data <= data_next;
        end
    end

    initial
    begin : driver
        addr_t addr;
        int    gap;
        int    hold;
        logic  mid_flush;
        rst            = 1'b1;
        flush          = 1'b0;
        fetch_req      = 1'b0;
        fetch_req_data = '0;
        expect_addr    = '0;
        misses         = 0;
        void'($urandom(32'h8357));
        fill_image();
        clear_lines();
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        repeat (5)
        begin
            @(negedge clk);
            if (fetch_ack !== 1'b0 || mem_req !== 1'b0)
            begin
                $display("fetch_ack or mem_req went high before any request.");
                end_with_failure();
            end
        end

        for (int i = 0; i < NUM_FETCHES; i++)
        begin
            gap = $urandom % 4;
            repeat (gap) @(posedge clk);
            if (($urandom % 16) == 0)
            begin
                pulse_flush();
                clear_lines();
            end
            addr      = addr_t'(WINDOW_BASE + ($urandom % WINDOW_WORDS));
            hold      = $urandom % 4;
            mid_flush = (($urandom % 16) == 0);
            run_fetch(addr, hold, mid_flush);
        end

        check_count(mem_count, misses);
        $display("Simulation passed");
        $finish;
    end

endmodule

// File: hdl/icache_top.sv
`timescale 1ns/100ps

module icache_top
    import icache_pkg::*;
#(
    parameter int INDEX_BITS = 4
)
(
    input  logic       clk,
    input  logic       rst,
    input  logic       flush,
    input  logic       fetch_req,
    input  fetch_req_t fetch_req_data,
    input  logic       mem_ack,
    input  word_t      mem_data,
    output logic       fetch_ack,
    output fetch_rsp_t fetch_rsp,
    output logic       mem_req,
    output addr_t      mem_addr
);

    logic        lookup_valid;
    fetch_req_t  lookup_req;
    logic        lookup_done;
    fetch_rsp_t  lookup_rsp;
    logic        busy;
    logic        refill_start;
    refill_req_t refill_req;
    logic        refill_done;
    refill_rsp_t refill_rsp;

    fetch_port u_fetch_port (
        .clk            (clk),
        .rst            (rst),
        .fetch_req      (fetch_req),
        .fetch_req_data (fetch_req_data),
        .lookup_done    (lookup_done),
        .lookup_rsp     (lookup_rsp),
        .fetch_ack      (fetch_ack),
        .fetch_rsp      (fetch_rsp),
        .lookup_valid   (lookup_valid),
        .lookup_req     (lookup_req),
        .busy           (busy)
    );

    icache_core #(
        .INDEX_BITS (INDEX_BITS)
    ) u_icache_core (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .busy         (busy),
        .lookup_valid (lookup_valid),
        .lookup_req   (lookup_req),
        .refill_done  (refill_done),
        .refill_rsp   (refill_rsp),
        .lookup_done  (lookup_done),
        .lookup_rsp   (lookup_rsp),
        .refill_start (refill_start),
        .refill_req   (refill_req)
    );

    refill_port u_refill_port (
        .clk          (clk),
        .rst          (rst),
        .refill_start (refill_start),
        .refill_req   (refill_req),
        .mem_ack      (mem_ack),
        .mem_data     (mem_data),
        .refill_done  (refill_done),
        .refill_rsp   (refill_rsp),
        .mem_req      (mem_req),
        .mem_addr     (mem_addr)
    );

endmodule

// File: hdl/icache_core.sv
`timescale 1ns/100ps

module icache_core
    import icache_pkg::*;
#(
    parameter int INDEX_BITS = 4
)
(
    input  logic        clk,
    input  logic        rst,
    input  logic        flush,
    input  logic        busy,
    input  logic        lookup_valid,
    input  fetch_req_t  lookup_req,
    input  logic        refill_done,
    input  refill_rsp_t refill_rsp,
    output logic        lookup_done,
    output fetch_rsp_t  lookup_rsp,
    output logic        refill_start,
    output refill_req_t refill_req
);

    localparam int TAG_BITS = ADDR_BITS - INDEX_BITS;
    localparam int LINES    = 1 << INDEX_BITS;

    localparam logic [1:0] ST_IDLE    = 2'd0;
    localparam logic [1:0] ST_COMPARE = 2'd1;
    localparam logic [1:0] ST_ALLOC   = 2'd2;

    // ####################
    // Storage
    // ####################

    logic [TAG_BITS-1:0] tag_mem [LINES];
    word_t               data_mem [LINES];
    logic [LINES-1:0]    valid_q;

    logic [1:0]            state;
    addr_t                 addr_q;
    logic [TAG_BITS-1:0]   tag_rd;
    word_t                 data_rd;
    word_t                 fill_word;
    logic                  fill_done;
    logic                  flush_pending;
    logic                  tag_match;

    logic [INDEX_BITS-1:0] index_in;
    logic [INDEX_BITS-1:0] index_q;
    logic [TAG_BITS-1:0]   tag_q;

    assign index_in = lookup_req.addr[INDEX_BITS-1:0];
    assign index_q  = addr_q[INDEX_BITS-1:0];
    assign tag_q    = addr_q[ADDR_BITS-1:INDEX_BITS];

    // Arrays are read on the lookup and written when a refill returns.
    always_ff @(posedge clk)
    begin
        if (lookup_valid)
        begin
            addr_q  <= lookup_req.addr;
            tag_rd  <= tag_mem[index_in];
            data_rd <= data_mem[index_in];
        end
        if (state == ST_ALLOC && refill_done)
        begin
            tag_mem[index_q]  <= tag_q;
            data_mem[index_q] <= refill_rsp.data;
            fill_word         <= refill_rsp.data;
        end
    end

    // ####################
    // Lookup
    // ####################

    // Valid bits sit in flops, so they are read directly in the compare state.
    assign tag_match = valid_q[index_q] && (tag_rd == tag_q);

    assign lookup_done  = (state == ST_COMPARE && tag_match) || fill_done;
    assign refill_start = (state == ST_COMPARE) && !tag_match;

    assign refill_req.addr = addr_q;

    // After a refill the answer carries the new word with hit clear.
    always_comb
    begin
        if (fill_done)
        begin
            lookup_rsp.data = fill_word;
            lookup_rsp.hit  = 1'b0;
        end
        else
        begin
            lookup_rsp.data = data_rd;
            lookup_rsp.hit  = 1'b1;
        end
    end

    // ####################
    // Control
    // ####################

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state         <= ST_IDLE;
            fill_done     <= 1'b0;
            flush_pending <= 1'b0;
            valid_q       <= '0;
        end
        else
        begin
            fill_done <= 1'b0;
            case (state)
                ST_IDLE:
                begin
                    if (lookup_valid)
                        state <= ST_COMPARE;
                end
                ST_COMPARE:
                begin
                    if (tag_match)
                        state <= ST_IDLE;
                    else
                        state <= ST_ALLOC;
                end
                ST_ALLOC:
                begin
                    // Wait here for as long as memory takes.
                    if (refill_done)
                    begin
                        valid_q[index_q] <= 1'b1;
                        fill_done        <= 1'b1;
                        state            <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase

            // A flush during a fetch waits until the fetch port goes idle.
            if ((flush || flush_pending) && !busy)
            begin
                valid_q       <= '0;
                flush_pending <= 1'b0;
            end
            else if (flush)
            begin
                flush_pending <= 1'b1;
            end
        end
    end

    // The fetch port issues a lookup only when the previous one is finished.
    lookup_in_idle: assert property (@(posedge clk) disable iff (rst)
        lookup_valid |-> state == ST_IDLE);

endmodule

// File: hdl/refill_port.sv
`timescale 1ns/100ps

module refill_port
    import icache_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        refill_start,
    input  refill_req_t refill_req,
    input  logic        mem_ack,
    input  word_t       mem_data,
    output logic        refill_done,
    output refill_rsp_t refill_rsp,
    output logic        mem_req,
    output addr_t       mem_addr
);

    localparam logic [1:0] ST_IDLE    = 2'd0;
    localparam logic [1:0] ST_REQUEST = 2'd1;
    localparam logic [1:0] ST_RELEASE = 2'd2;
    localparam logic [1:0] ST_DROP    = 2'd3;

    logic [1:0] state;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state       <= ST_IDLE;
            mem_req     <= 1'b0;
            refill_done <= 1'b0;
        end
        else
        begin
            refill_done <= 1'b0;
            case (state)
                ST_IDLE:
                begin
                    if (refill_start)
                    begin
                        mem_req <= 1'b1;
                        state   <= ST_REQUEST;
                    end
                end
                ST_REQUEST:
                begin
                    if (mem_ack)
                    begin
                        refill_done <= 1'b1;
                        state       <= ST_RELEASE;
                    end
                end
                ST_RELEASE:
                begin
                    mem_req <= 1'b0;
                    state   <= ST_DROP;
                end
                ST_DROP:
                begin
                    // No new request until memory has let go of its ack.
                    if (!mem_ack)
                        state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Address is held for the whole request, data is taken on the ack.
    always_ff @(posedge clk)
    begin
        if (state == ST_IDLE && refill_start)
            mem_addr <= refill_req.addr;
        if (state == ST_REQUEST && mem_ack)
            refill_rsp.data <= mem_data;
    end

    // The request is only withdrawn once memory has answered it.
    req_held_to_ack: assert property (@(posedge clk) disable iff (rst)
        $fell(mem_req) |-> $past(mem_ack));

endmodule

// File: hdl/fetch_port.sv
`timescale 1ns/100ps

module fetch_port
    import icache_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       fetch_req,
    input  fetch_req_t fetch_req_data,
    input  logic       lookup_done,
    input  fetch_rsp_t lookup_rsp,
    output logic       fetch_ack,
    output fetch_rsp_t fetch_rsp,
    output logic       lookup_valid,
    output fetch_req_t lookup_req,
    output logic       busy
);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_WAIT = 2'd1;
    localparam logic [1:0] ST_ACK  = 2'd2;

    logic [1:0] state;
    logic       req_q;
    logic       req_rise;

    // A new request is only taken on a rising edge of fetch_req.
    assign req_rise = fetch_req && !req_q;

    // The port is busy from the accepted request until the ack has dropped.
    assign busy = (state != ST_IDLE);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state        <= ST_IDLE;
            req_q        <= 1'b0;
            fetch_ack    <= 1'b0;
            lookup_valid <= 1'b0;
        end
        else
        begin
            req_q        <= fetch_req;
            lookup_valid <= 1'b0;
            case (state)
                ST_IDLE:
                begin
                    if (req_rise)
                    begin
                        lookup_valid <= 1'b1;
                        state        <= ST_WAIT;
                    end
                end
                ST_WAIT:
                begin
                    if (lookup_done)
                    begin
                        fetch_ack <= 1'b1;
                        state     <= ST_ACK;
                    end
                end
                ST_ACK:
                begin
                    if (!fetch_req)
                    begin
                        fetch_ack <= 1'b0;
                        state     <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Request address and response are plain payload registers.
    always_ff @(posedge clk)
    begin
        if (state == ST_IDLE && req_rise)
            lookup_req <= fetch_req_data;
        if (state == ST_WAIT && lookup_done)
            fetch_rsp <= lookup_rsp;
    end

    // The fetch unit must still hold its request when the ack goes up.
    ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        $rose(fetch_ack) |-> fetch_req);

endmodule

// File: hdl/icache_pkg.sv
package icache_pkg;

    // ####################
    // Widths
    // ####################

    // Word addresses and instruction words.
    localparam int ADDR_BITS = 16;
    localparam int DATA_BITS = 32;

    typedef logic [ADDR_BITS-1:0] addr_t;
    typedef logic [DATA_BITS-1:0] word_t;

    // ####################
    // Fetch side
    // ####################

    // Address of the word that the fetch unit wants.
    typedef struct packed {
        addr_t addr;
    } fetch_req_t;

    // Returned instruction, with hit set when it came from the cache.
    typedef struct packed {
        word_t data;
        logic  hit;
    } fetch_rsp_t;

    // ####################
    // Memory side
    // ####################

    // One word is read from memory per refill.
    typedef struct packed {
        addr_t addr;
    } refill_req_t;

    typedef struct packed {
        word_t data;
    } refill_rsp_t;

endpackage
